//--- Bender.yml
package:
  name: bn_alu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bn_alu_pkg.sv
      - verilog/bn_alu_decoder.sv
      - verilog/bn_alu_shifter.sv
      - verilog/bn_alu_adders.sv
      - verilog/bn_alu_logic.sv
      - verilog/bn_alu_ispr.sv
      - verilog/bn_alu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_bn_alu.sv

//--- files.f
+incdir+verilog
verilog/bn_alu_pkg.sv
verilog/bn_alu_decoder.sv
verilog/bn_alu_shifter.sv
verilog/bn_alu_adders.sv
verilog/bn_alu_logic.sv
verilog/bn_alu_ispr.sv
verilog/bn_alu_top.sv
verif/tb_bn_alu.sv

//--- verif/tb_bn_alu.sv
// Bignum ALU testbench
// Directed tests against a reference model of the arithmetic, logic and register rules

`default_nettype none

`include "bn_alu_settings.svh"

module tb_bn_alu;

  localparam int unsigned wlen = `BN_WLEN;
  // Limit leaves wide margin over about 150 cycles of tests
  localparam int unsigned max_cycles = 2000;

  logic                          clk_i;
  logic                          rst_ni;
  bn_alu_pkg::alu_op_e           op_i;
  logic [wlen-1:0]               operand_a_i;
  logic [wlen-1:0]               operand_b_i;
  logic [`BN_SHIFT_W-1:0]        shift_amt_i;
  logic                          shift_right_i;
  logic                          flag_group_i;
  bn_alu_pkg::flag_e             sel_flag_i;
  logic                          flag_en_i;
  bn_alu_pkg::ispr_e             ispr_addr_i;
  logic [`BN_BASE_WLEN-1:0]      ispr_base_wdata_i;
  logic [`BN_BASE_WORDS-1:0]     ispr_base_wr_en_i;
  logic [wlen-1:0]               ispr_bignum_wdata_i;
  logic                          ispr_bignum_wr_en_i;
  logic                          ispr_init_i;
  logic [wlen-1:0]               result_o;
  logic                          sel_flag_o;
  logic [wlen-1:0]               ispr_rdata_o;

  integer          seed;
  int unsigned     errors;
  int unsigned     checks;
  int unsigned     cycles;
  // Reference state of the flag groups as {C, M, L, Z} and of MOD
  logic [3:0]      model_flags [2];
  logic [wlen-1:0] model_mod;
  logic [wlen-1:0] op_res;

  bn_alu_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: simulation did not finish within %0d cycles", max_cycles);
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [wlen-1:0] got,
                             input logic [wlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic make_word(output logic [wlen-1:0] w);
    for (int i = 0; i < wlen / 32; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  task automatic model_op(input bn_alu_pkg::alu_op_e op, input logic [wlen-1:0] a,
                          input logic [wlen-1:0] b, input logic [7:0] amt,
                          input logic right, input logic grp,
                          output logic [wlen-1:0] res, output logic [3:0] flg,
                          output logic wr);
    logic [wlen-1:0]   shb;
    logic [wlen:0]     wide;
    logic [2*wlen-1:0] cat;
    logic              cin;
    shb  = right ? (b >> amt) : (b << amt);
    cin  = model_flags[grp][3];
    flg  = model_flags[grp];
    wr   = 1'b0;
    wide = '0;
    case (op)
      bn_alu_pkg::alu_add:  wide = {1'b0, a} + {1'b0, shb};
      bn_alu_pkg::alu_addc: wide = {1'b0, a} + {1'b0, shb} + cin;
      // Bit wlen of the difference is the borrow
      bn_alu_pkg::alu_sub:  wide = {1'b0, a} - {1'b0, shb};
      bn_alu_pkg::alu_subb: wide = {1'b0, a} - {1'b0, shb} - cin;
      default: ;
    endcase
    case (op)
      bn_alu_pkg::alu_add, bn_alu_pkg::alu_addc,
      bn_alu_pkg::alu_sub, bn_alu_pkg::alu_subb: begin
        res = wide[wlen-1:0];
        flg = {wide[wlen], res[wlen-1], res[0], res == {wlen{1'b0}}};
        wr  = 1'b1;
      end
      bn_alu_pkg::alu_addm: begin
        // Unshifted B and one conditional MOD subtraction
        wide = {1'b0, a} + {1'b0, b};
        if (wide >= {1'b0, model_mod}) wide = wide - {1'b0, model_mod};
        res = wide[wlen-1:0];
      end
      bn_alu_pkg::alu_subm: begin
        res = a - b;
        if (a < b) res = res + model_mod;
      end
      bn_alu_pkg::alu_rshi: begin
        cat = {a, b} >> amt;
        res = cat[wlen-1:0];
      end
      default: begin
        case (op)
          bn_alu_pkg::alu_xor: res = a ^ shb;
          bn_alu_pkg::alu_or:  res = a | shb;
          bn_alu_pkg::alu_and: res = a & shb;
          default:             res = ~shb;
        endcase
        // Logic ops keep C
        flg = {cin, res[wlen-1], res[0], res == {wlen{1'b0}}};
        wr  = 1'b1;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Bus helpers
  ////////////////////////////////////////////////////////////

  task automatic clear_strobes();
    ispr_base_wr_en_i   = '0;
    ispr_bignum_wr_en_i = 1'b0;
    ispr_init_i         = 1'b0;
    flag_en_i           = 1'b0;
  endtask

  // Drive one operation and compare the combinational result
  task automatic run_op(input bn_alu_pkg::alu_op_e op, input logic [wlen-1:0] a,
                        input logic [wlen-1:0] b, input logic [7:0] amt,
                        input logic right, input logic grp, input logic fen);
    logic [wlen-1:0] exp_res;
    logic [3:0]      exp_flg;
    logic            wr;
    model_op(op, a, b, amt, right, grp, exp_res, exp_flg, wr);
    @(negedge clk_i);
    clear_strobes();
    op_i          = op;
    operand_a_i   = a;
    operand_b_i   = b;
    shift_amt_i   = amt;
    shift_right_i = right;
    flag_group_i  = grp;
    flag_en_i     = fen;
    #5;
    check_value("result_o", result_o, exp_res);
    op_res = result_o;
    if (fen && wr) model_flags[grp] = exp_flg;
  endtask

  task automatic read_ispr(input bn_alu_pkg::ispr_e addr, input logic [wlen-1:0] exp);
    @(negedge clk_i);
    clear_strobes();
    ispr_addr_i = addr;
    #5;
    check_value("ispr_rdata_o", ispr_rdata_o, exp);
  endtask

  task automatic check_flags();
    read_ispr(bn_alu_pkg::ispr_flags, {{(wlen-8){1'b0}}, model_flags[1], model_flags[0]});
  endtask

  // Walk every flag select of one group
  task automatic check_sel(input logic grp);
    for (int s = 0; s < 4; s++) begin
      @(negedge clk_i);
      clear_strobes();
      flag_group_i = grp;
      sel_flag_i   = bn_alu_pkg::flag_e'(s[1:0]);
      #5;
      check_value("sel_flag_o", sel_flag_o, model_flags[grp][3-s]);
    end
  endtask

  task automatic write_base(input bn_alu_pkg::ispr_e addr, input int idx,
                            input logic [31:0] data);
    @(negedge clk_i);
    clear_strobes();
    ispr_addr_i            = addr;
    ispr_base_wdata_i      = data;
    ispr_base_wr_en_i[idx] = 1'b1;
    if (addr == bn_alu_pkg::ispr_mod) model_mod[idx*32 +: 32] = data;
    else {model_flags[1], model_flags[0]} = data[7:0];
  endtask

  task automatic write_bignum(input logic [wlen-1:0] data);
    @(negedge clk_i);
    clear_strobes();
    ispr_addr_i         = bn_alu_pkg::ispr_mod;
    ispr_bignum_wdata_i = data;
    ispr_bignum_wr_en_i = 1'b1;
    model_mod           = data;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_after_reset();
    check_flags();
    read_ispr(bn_alu_pkg::ispr_mod, '0);
    check_sel(1'b0);
    check_sel(1'b1);
  endtask

  task automatic exercise_add_sub();
    logic [wlen-1:0] a;
    logic [wlen-1:0] b;
    logic [7:0]      amt;
    for (int i = 0; i < 8; i++) begin
      make_word(a);
      make_word(b);
      amt = $random(seed);
      run_op(i[2] ? bn_alu_pkg::alu_sub : bn_alu_pkg::alu_add, a, b, amt, i[0], i[1], 1'b1);
      check_flags();
    end
    // Carry out and a zero result
    run_op(bn_alu_pkg::alu_add, '1, 1, 0, 1'b1, 1'b0, 1'b1);
    check_flags();
    run_op(bn_alu_pkg::alu_sub, a, a, 0, 1'b1, 1'b1, 1'b1);
    check_flags();
  endtask

  task automatic run_carry_chain();
    logic [wlen-1:0]   al;
    logic [wlen-1:0]   ah;
    logic [wlen-1:0]   bl;
    logic [wlen-1:0]   bh;
    logic [wlen-1:0]   lo;
    logic [2*wlen-1:0] full;
    make_word(ah);
    make_word(bh);
    make_word(bl);
    bl[wlen-1] = 1'b1;
    al = bl >> 1;
    // Group 0 holds a clear C while group 1 chains a set one
    write_base(bn_alu_pkg::ispr_flags, 0, 32'h07);
    run_op(bn_alu_pkg::alu_sub, al, bl, 0, 1'b1, 1'b1, 1'b1);
    lo = op_res;
    run_op(bn_alu_pkg::alu_subb, ah, bh, 0, 1'b1, 1'b1, 1'b1);
    full = {ah, al} - {bh, bl};
    check_value("subb chain low", lo, full[wlen-1:0]);
    check_value("subb chain high", op_res, full[2*wlen-1:wlen]);
    check_flags();
    run_op(bn_alu_pkg::alu_add, '1, bl, 0, 1'b1, 1'b1, 1'b1);
    lo = op_res;
    run_op(bn_alu_pkg::alu_addc, ah, bh, 0, 1'b1, 1'b1, 1'b1);
    full = {ah, {wlen{1'b1}}} + {bh, bl};
    check_value("addc chain low", lo, full[wlen-1:0]);
    check_value("addc chain high", op_res, full[2*wlen-1:wlen]);
    check_flags();
  endtask

  task automatic exercise_mod_ops();
    logic [wlen-1:0] m;
    logic [wlen-1:0] a;
    logic [wlen-1:0] b;
    make_word(m);
    write_bignum(m);
    read_ispr(bn_alu_pkg::ispr_mod, model_mod);
    make_word(m);
    m[wlen-1] = 1'b1;
    for (int w = 0; w < `BN_BASE_WORDS; w++) begin
      write_base(bn_alu_pkg::ispr_mod, w, m[w*32 +: 32]);
    end
    read_ispr(bn_alu_pkg::ispr_mod, model_mod);
    for (int i = 0; i < 8; i++) begin
      make_word(a);
      make_word(b);
      a = a % m;
      b = b % m;
      run_op(i[0] ? bn_alu_pkg::alu_subm : bn_alu_pkg::alu_addm, a, b, 0, 1'b1, i[1], 1'b1);
    end
    check_flags();
  endtask

  task automatic exercise_logic_ops();
    logic [wlen-1:0] a;
    logic [wlen-1:0] b;
    logic [7:0]      amt;
    // Group 0 with C set, group 1 with C clear
    write_base(bn_alu_pkg::ispr_flags, 0, 32'h39);
    check_flags();
    for (int i = 0; i < 8; i++) begin
      make_word(a);
      make_word(b);
      amt = $random(seed);
      run_op(bn_alu_pkg::alu_op_e'(7 + i % 4), a, b, amt, i[0], i[2], 1'b1);
      check_flags();
      check_sel(i[2]);
    end
    // rshi with flags enabled still leaves them alone
    for (int i = 0; i < 4; i++) begin
      make_word(a);
      make_word(b);
      amt = $random(seed);
      run_op(bn_alu_pkg::alu_rshi, a, b, amt, i[0], i[1], 1'b1);
    end
    check_flags();
  endtask

  task automatic check_init_clear();
    @(negedge clk_i);
    clear_strobes();
    ispr_init_i = 1'b1;
    model_flags[0] = '0;
    model_flags[1] = '0;
    model_mod      = '0;
    check_flags();
    read_ispr(bn_alu_pkg::ispr_mod, '0);
    check_sel(1'b0);
  endtask

  initial begin
    seed                = 13648;
    errors              = 0;
    checks              = 0;
    model_flags[0]      = '0;
    model_flags[1]      = '0;
    model_mod           = '0;
    op_res              = '0;
    rst_ni              = 1'b0;
    op_i                = bn_alu_pkg::alu_add;
    operand_a_i         = '0;
    operand_b_i         = '0;
    shift_amt_i         = '0;
    shift_right_i       = 1'b1;
    flag_group_i        = 1'b0;
    sel_flag_i          = bn_alu_pkg::sel_c;
    ispr_addr_i         = bn_alu_pkg::ispr_flags;
    ispr_base_wdata_i   = '0;
    ispr_bignum_wdata_i = '0;
    clear_strobes();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    check_after_reset();
    exercise_add_sub();
    run_carry_chain();
    exercise_mod_ops();
    exercise_logic_ops();
    check_init_clear();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bn_alu_adders.sv
// Bignum ALU adders X and Y
// Add/sub with shifted operand, pseudo-mod add/sub against MOD, arithmetic flags

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_adders (
  input  logic [`BN_WLEN-1:0]   operand_a_i,
  input  logic [`BN_WLEN-1:0]   operand_b_i,
  input  logic [`BN_WLEN-1:0]   shift_res_i,
  input  logic [`BN_WLEN-1:0]   mod_i,
  input  bn_alu_pkg::mod_mode_e mod_mode_i,
  input  logic                  y_carry_in_i,
  input  logic                  y_invert_i,
  output logic [`BN_WLEN-1:0]   arith_res_o,
  output bn_alu_pkg::flags_t    adder_flags_o
);

  logic                x_invert;
  logic [`BN_WLEN-1:0] x_op_b;
  logic [`BN_WLEN:0]   x_sum;
  logic                x_carry;

  logic                pmod;
  logic [`BN_WLEN-1:0] y_op_a;
  logic [`BN_WLEN-1:0] y_op_b;
  logic [`BN_WLEN:0]   y_sum;
  logic                y_carry;

  ////////////////////////////////////////////////////////////
  // Adder X, only used by addm and subm
  ////////////////////////////////////////////////////////////

  // subm computes A + ~B + 1
  assign x_invert = (mod_mode_i == bn_alu_pkg::mod_sub);
  assign x_op_b   = x_invert ? ~operand_b_i : operand_b_i;
  assign x_sum    = {1'b0, operand_a_i} + {1'b0, x_op_b} + {{`BN_WLEN{1'b0}}, x_invert};
  assign x_carry  = x_sum[`BN_WLEN];

  ////////////////////////////////////////////////////////////
  // Adder Y
  ////////////////////////////////////////////////////////////

  assign pmod = (mod_mode_i != bn_alu_pkg::mod_none);

  // X result against MOD, or A against the shifter
  assign y_op_a  = pmod ? x_sum[`BN_WLEN-1:0] : operand_a_i;
  assign y_op_b  = pmod ? mod_i : shift_res_i;
  assign y_sum   = {1'b0, y_op_a} + {1'b0, (y_invert_i ? ~y_op_b : y_op_b)} +
                   {{`BN_WLEN{1'b0}}, y_carry_in_i};
  assign y_carry = y_sum[`BN_WLEN];

  ////////////////////////////////////////////////////////////
  // Result choice
  ////////////////////////////////////////////////////////////

  always_comb begin
    arith_res_o = y_sum[`BN_WLEN-1:0];
    case (mod_mode_i)
      // Reduce when A + B overflowed or A + B >= MOD
      bn_alu_pkg::mod_add: begin
        arith_res_o = (x_carry | y_carry) ? y_sum[`BN_WLEN-1:0] : x_sum[`BN_WLEN-1:0];
      end
      // No borrow from A - B means no MOD correction
      bn_alu_pkg::mod_sub: begin
        arith_res_o = x_carry ? x_sum[`BN_WLEN-1:0] : y_sum[`BN_WLEN-1:0];
      end
      default: ;
    endcase
  end

  // Flags from the Y result, C is the borrow for subtraction
  assign adder_flags_o.C = y_invert_i ? ~y_carry : y_carry;
  assign adder_flags_o.M = y_sum[`BN_WLEN-1];
  assign adder_flags_o.L = y_sum[0];
  assign adder_flags_o.Z = ~|y_sum[`BN_WLEN-1:0];

endmodule

`default_nettype wire

//--- verilog/bn_alu_decoder.sv
// Bignum ALU operation decoder
// Turns the operation code into steering for shifter, adders, logic unit and flags

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_decoder (
  input  bn_alu_pkg::alu_op_e     op_i,
  input  logic                    shift_right_i,
  input  logic                    flag_en_i,
  input  logic                    flag_c_i,
  output logic                    shift_right_o,
  output logic                    use_a_o,
  output logic                    y_carry_in_o,
  output logic                    y_invert_o,
  output logic                    adder_flags_we_o,
  output logic                    logic_flags_we_o,
  output bn_alu_pkg::mod_mode_e   mod_mode_o,
  output bn_alu_pkg::result_sel_e result_sel_o
);

  logic adder_we_raw;
  logic logic_we_raw;

  always_comb begin
    // Defaults: plain Y add, shifter direction from the operation
    shift_right_o = shift_right_i;
    use_a_o       = 1'b0;
    y_carry_in_o  = 1'b0;
    y_invert_o    = 1'b0;
    adder_we_raw  = 1'b0;
    logic_we_raw  = 1'b0;
    mod_mode_o    = bn_alu_pkg::mod_none;
    result_sel_o  = bn_alu_pkg::res_arith;

    case (op_i)
      bn_alu_pkg::alu_add: begin
        adder_we_raw = 1'b1;
      end
      bn_alu_pkg::alu_addc: begin
        // Carry in from the selected group
        y_carry_in_o = flag_c_i;
        adder_we_raw = 1'b1;
      end
      bn_alu_pkg::alu_addm: begin
        // Y subtracts MOD from the X sum
        y_carry_in_o = 1'b1;
        y_invert_o   = 1'b1;
        mod_mode_o   = bn_alu_pkg::mod_add;
      end
      bn_alu_pkg::alu_sub: begin
        // A + ~B + 1
        y_carry_in_o = 1'b1;
        y_invert_o   = 1'b1;
        adder_we_raw = 1'b1;
      end
      bn_alu_pkg::alu_subb: begin
        // Borrow in is the inverted carry flag
        y_carry_in_o = ~flag_c_i;
        y_invert_o   = 1'b1;
        adder_we_raw = 1'b1;
      end
      bn_alu_pkg::alu_subm: begin
        // Y adds MOD back to the X difference
        mod_mode_o = bn_alu_pkg::mod_sub;
      end
      bn_alu_pkg::alu_rshi: begin
        // {A, B} >> shift_amt, no flags
        shift_right_o = 1'b1;
        use_a_o       = 1'b1;
        result_sel_o  = bn_alu_pkg::res_shift;
      end
      bn_alu_pkg::alu_xor,
      bn_alu_pkg::alu_or,
      bn_alu_pkg::alu_and,
      bn_alu_pkg::alu_not: begin
        logic_we_raw = 1'b1;
        result_sel_o = bn_alu_pkg::res_logic;
      end
      default: ;
    endcase
  end

  // Flags only written when the operation asks for it
  assign adder_flags_we_o = flag_en_i & adder_we_raw;
  assign logic_flags_we_o = flag_en_i & logic_we_raw;

endmodule

`default_nettype wire

//--- verilog/bn_alu_ispr.sv
// Bignum ALU special registers
// Flag groups, MOD register, readback mux and flag-select output

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_ispr (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  bn_alu_pkg::ispr_e            ispr_addr_i,
  input  logic [`BN_BASE_WLEN-1:0]     ispr_base_wdata_i,
  input  logic [`BN_BASE_WORDS-1:0]    ispr_base_wr_en_i,
  input  logic [`BN_WLEN-1:0]          ispr_bignum_wdata_i,
  input  logic                         ispr_bignum_wr_en_i,
  input  logic                         ispr_init_i,
  input  logic                         flag_group_i,
  input  bn_alu_pkg::flag_e            sel_flag_i,
  input  bn_alu_pkg::flags_t           adder_flags_i,
  input  bn_alu_pkg::flags_t           logic_flags_i,
  input  logic                         adder_flags_we_i,
  input  logic                         logic_flags_we_i,
  output logic [`BN_WLEN-1:0]          ispr_rdata_o,
  output logic [`BN_WLEN-1:0]          mod_o,
  output logic                         flag_c_o,
  output logic                         sel_flag_o
);

  localparam int unsigned FlagBits = `BN_FLAG_GROUPS * `BN_FLAGS_W;

  bn_alu_pkg::flags_t  flags_q [`BN_FLAG_GROUPS];
  bn_alu_pkg::flags_t  flags_d [`BN_FLAG_GROUPS];
  logic [FlagBits-1:0] flags_flat;
  logic                flags_wr;
  bn_alu_pkg::flags_t  cur_flags;
  logic [`BN_WLEN-1:0] mod_q;

  ////////////////////////////////////////////////////////////
  // Flag groups
  ////////////////////////////////////////////////////////////

  // FLAGS base write hits word 0 only
  assign flags_wr = ispr_base_wr_en_i[0] & (ispr_addr_i == bn_alu_pkg::ispr_flags);

  for (genvar g = 0; g < `BN_FLAG_GROUPS; g++) begin : g_flags
    logic op_hit;

    // Operation flags land only in the addressed group
    assign op_hit = (flag_group_i == g) & (adder_flags_we_i | logic_flags_we_i);

    always_comb begin
      flags_d[g] = ispr_base_wdata_i[g*`BN_FLAGS_W +: `BN_FLAGS_W];
      if (ispr_init_i) begin
        flags_d[g] = '0;
      end else if (adder_flags_we_i && (flag_group_i == g)) begin
        flags_d[g] = adder_flags_i;
      end else if (logic_flags_we_i && (flag_group_i == g)) begin
        flags_d[g] = logic_flags_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        flags_q[g] <= '0;
      end else if (ispr_init_i || op_hit || flags_wr) begin
        flags_q[g] <= flags_d[g];
      end
    end

    assign flags_flat[g*`BN_FLAGS_W +: `BN_FLAGS_W] = flags_q[g];
  end

  ////////////////////////////////////////////////////////////
  // MOD register, written per base word or whole
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < `BN_BASE_WORDS; w++) begin : g_mod
    logic mod_we;

    assign mod_we = ispr_init_i | ((ispr_addr_i == bn_alu_pkg::ispr_mod) &
                                   (ispr_base_wr_en_i[w] | ispr_bignum_wr_en_i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mod_q[w*`BN_BASE_WLEN +: `BN_BASE_WLEN] <= '0;
      end else if (mod_we) begin
        if (ispr_init_i) begin
          mod_q[w*`BN_BASE_WLEN +: `BN_BASE_WLEN] <= '0;
        end else if (ispr_base_wr_en_i[w]) begin
          mod_q[w*`BN_BASE_WLEN +: `BN_BASE_WLEN] <= ispr_base_wdata_i;
        end else begin
          mod_q[w*`BN_BASE_WLEN +: `BN_BASE_WLEN] <=
            ispr_bignum_wdata_i[w*`BN_BASE_WLEN +: `BN_BASE_WLEN];
        end
      end
    end
  end

  assign mod_o = mod_q;

  // Readback, flags zero-extended
  assign ispr_rdata_o = (ispr_addr_i == bn_alu_pkg::ispr_flags) ?
                        {{(`BN_WLEN - FlagBits){1'b0}}, flags_flat} : mod_q;

  // Selected group feeds carry and conditional select
  assign cur_flags = flags_q[flag_group_i];
  assign flag_c_o  = cur_flags.C;

  always_comb begin
    case (sel_flag_i)
      bn_alu_pkg::sel_m: sel_flag_o = cur_flags.M;
      bn_alu_pkg::sel_l: sel_flag_o = cur_flags.L;
      bn_alu_pkg::sel_z: sel_flag_o = cur_flags.Z;
      default:           sel_flag_o = cur_flags.C;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/bn_alu_logic.sv
// Bignum ALU logic unit
// XOR, OR, AND of A with the shifted operand, NOT of the shifted operand

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_logic (
  input  bn_alu_pkg::alu_op_e op_i,
  input  logic [`BN_WLEN-1:0] operand_a_i,
  input  logic [`BN_WLEN-1:0] shift_res_i,
  input  logic                flag_c_i,
  output logic [`BN_WLEN-1:0] logic_res_o,
  output bn_alu_pkg::flags_t  logic_flags_o
);

  always_comb begin
    case (op_i)
      bn_alu_pkg::alu_xor: logic_res_o = operand_a_i ^ shift_res_i;
      bn_alu_pkg::alu_or:  logic_res_o = operand_a_i | shift_res_i;
      bn_alu_pkg::alu_and: logic_res_o = operand_a_i & shift_res_i;
      default:             logic_res_o = ~shift_res_i;
    endcase
  end

  // C passes through unchanged
  assign logic_flags_o.C = flag_c_i;
  assign logic_flags_o.M = logic_res_o[`BN_WLEN-1];
  assign logic_flags_o.L = logic_res_o[0];
  assign logic_flags_o.Z = ~|logic_res_o;

endmodule

`default_nettype wire

//--- verilog/bn_alu_pkg.sv
// Bignum ALU package
// Operation codes, flag layout and steering types for the ALU blocks

`default_nettype none

`include "bn_alu_settings.svh"

package bn_alu_pkg;

  // Operation code
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_addc = 4'd1,
    alu_addm = 4'd2,
    alu_sub  = 4'd3,
    alu_subb = 4'd4,
    alu_subm = 4'd5,
    alu_rshi = 4'd6,
    alu_xor  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9,
    alu_not  = 4'd10
  } alu_op_e;

  // One flag group, C in the MSB
  typedef struct packed {
    logic C;
    logic M;
    logic L;
    logic Z;
  } flags_t;

  // Flag picked for conditional select
  typedef enum logic [1:0] {
    sel_c = 2'd0,
    sel_m = 2'd1,
    sel_l = 2'd2,
    sel_z = 2'd3
  } flag_e;

  // Special-register address
  typedef enum logic {
    ispr_mod   = 1'b0,
    ispr_flags = 1'b1
  } ispr_e;

  // Pseudo-mod mode for the adders
  typedef enum logic [1:0] {
    mod_none = 2'd0,
    mod_add  = 2'd1,
    mod_sub  = 2'd2
  } mod_mode_e;

  // Source of the ALU result
  typedef enum logic [1:0] {
    res_arith = 2'd0,
    res_shift = 2'd1,
    res_logic = 2'd2
  } result_sel_e;

endpackage

`default_nettype wire

//--- verilog/bn_alu_settings.svh
// Bignum ALU settings
// Word widths and counts shared by every block of the ALU

`ifndef BN_ALU_SETTINGS_SVH
`define BN_ALU_SETTINGS_SVH

// Data word width
`define BN_WLEN 256

// Base write port width and number of base words per data word
`define BN_BASE_WLEN 32
`define BN_BASE_WORDS 8

// Shift amount width
`define BN_SHIFT_W 8

// Flag groups and bits per group
`define BN_FLAG_GROUPS 2
`define BN_FLAGS_W 4

`endif

//--- verilog/bn_alu_shifter.sv
// Bignum ALU barrel shifter
// Concatenate-and-right-shift; left shifts reverse the lower half around it

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_shifter (
  input  logic [`BN_WLEN-1:0]    operand_a_i,
  input  logic [`BN_WLEN-1:0]    operand_b_i,
  input  logic [`BN_SHIFT_W-1:0] shift_amt_i,
  input  logic                   shift_right_i,
  input  logic                   use_a_i,
  output logic [`BN_WLEN-1:0]    shift_res_o
);

  logic [`BN_WLEN-1:0]   upper;
  logic [`BN_WLEN-1:0]   lower;
  logic [`BN_WLEN-1:0]   b_rev;
  logic [`BN_WLEN*2-1:0] shifted;
  logic [`BN_WLEN-1:0]   out_low;
  logic [`BN_WLEN-1:0]   out_rev;

  // A only on top for rshi
  assign upper = use_a_i ? operand_a_i : '0;

  // Bit reversal of B and of the shifted lower half
  for (genvar i = 0; i < `BN_WLEN; i++) begin : g_rev
    assign b_rev[i]   = operand_b_i[`BN_WLEN-1-i];
    assign out_rev[i] = out_low[`BN_WLEN-1-i];
  end

  assign lower = shift_right_i ? operand_b_i : b_rev;

  // One right shifter serves both directions
  assign shifted = {upper, lower} >> shift_amt_i;

  // Upper half of the shift is not needed
  assign out_low = shifted[`BN_WLEN-1:0];

  assign shift_res_o = shift_right_i ? out_low : out_rev;

endmodule

`default_nettype wire

//--- verilog/bn_alu_top.sv
// Bignum ALU top level
// Single-cycle 256-bit ALU with shifter, two adders, logic unit and special registers

`default_nettype none

`include "bn_alu_settings.svh"

module bn_alu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Operation
  input  bn_alu_pkg::alu_op_e       op_i,
  input  logic [`BN_WLEN-1:0]       operand_a_i,
  input  logic [`BN_WLEN-1:0]       operand_b_i,
  input  logic [`BN_SHIFT_W-1:0]    shift_amt_i,
  input  logic                      shift_right_i,
  input  logic                      flag_group_i,
  input  bn_alu_pkg::flag_e         sel_flag_i,
  input  logic                      flag_en_i,
  // Special-register port
  input  bn_alu_pkg::ispr_e         ispr_addr_i,
  input  logic [`BN_BASE_WLEN-1:0]  ispr_base_wdata_i,
  input  logic [`BN_BASE_WORDS-1:0] ispr_base_wr_en_i,
  input  logic [`BN_WLEN-1:0]       ispr_bignum_wdata_i,
  input  logic                      ispr_bignum_wr_en_i,
  input  logic                      ispr_init_i,
  // Results
  output logic [`BN_WLEN-1:0]       result_o,
  output logic                      sel_flag_o,
  output logic [`BN_WLEN-1:0]       ispr_rdata_o
);

  logic                    shift_right;
  logic                    use_a;
  logic                    y_carry_in;
  logic                    y_invert;
  logic                    adder_flags_we;
  logic                    logic_flags_we;
  bn_alu_pkg::mod_mode_e   mod_mode;
  bn_alu_pkg::result_sel_e result_sel;
  logic                    flag_c;
  logic [`BN_WLEN-1:0]     shift_res;
  logic [`BN_WLEN-1:0]     arith_res;
  logic [`BN_WLEN-1:0]     logic_res;
  logic [`BN_WLEN-1:0]     mod;
  bn_alu_pkg::flags_t      adder_flags;
  bn_alu_pkg::flags_t      logic_flags;

  bn_alu_decoder u_decoder (
    .op_i             (op_i),
    .shift_right_i    (shift_right_i),
    .flag_en_i        (flag_en_i),
    .flag_c_i         (flag_c),
    .shift_right_o    (shift_right),
    .use_a_o          (use_a),
    .y_carry_in_o     (y_carry_in),
    .y_invert_o       (y_invert),
    .adder_flags_we_o (adder_flags_we),
    .logic_flags_we_o (logic_flags_we),
    .mod_mode_o       (mod_mode),
    .result_sel_o     (result_sel)
  );

  bn_alu_shifter u_shifter (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .shift_amt_i   (shift_amt_i),
    .shift_right_i (shift_right),
    .use_a_i       (use_a),
    .shift_res_o   (shift_res)
  );

  bn_alu_adders u_adders (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .shift_res_i   (shift_res),
    .mod_i         (mod),
    .mod_mode_i    (mod_mode),
    .y_carry_in_i  (y_carry_in),
    .y_invert_i    (y_invert),
    .arith_res_o   (arith_res),
    .adder_flags_o (adder_flags)
  );

  bn_alu_logic u_logic (
    .op_i          (op_i),
    .operand_a_i   (operand_a_i),
    .shift_res_i   (shift_res),
    .flag_c_i      (flag_c),
    .logic_res_o   (logic_res),
    .logic_flags_o (logic_flags)
  );

  bn_alu_ispr u_ispr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ispr_addr_i         (ispr_addr_i),
    .ispr_base_wdata_i   (ispr_base_wdata_i),
    .ispr_base_wr_en_i   (ispr_base_wr_en_i),
    .ispr_bignum_wdata_i (ispr_bignum_wdata_i),
    .ispr_bignum_wr_en_i (ispr_bignum_wr_en_i),
    .ispr_init_i         (ispr_init_i),
    .flag_group_i        (flag_group_i),
    .sel_flag_i          (sel_flag_i),
    .adder_flags_i       (adder_flags),
    .logic_flags_i       (logic_flags),
    .adder_flags_we_i    (adder_flags_we),
    .logic_flags_we_i    (logic_flags_we),
    .ispr_rdata_o        (ispr_rdata_o),
    .mod_o               (mod),
    .flag_c_o            (flag_c),
    .sel_flag_o          (sel_flag_o)
  );

  // Result mux
  always_comb begin
    case (result_sel)
      bn_alu_pkg::res_shift: result_o = shift_res;
      bn_alu_pkg::res_logic: result_o = logic_res;
      default:               result_o = arith_res;
    endcase
  end

endmodule

`default_nettype wire
